// ==== rtl/hwpe_regmap_pkg.sv ====
// ===================================================================
// Register map of the HWPE control slave
// Word indices, bus widths, sizes and timing constants
// ===================================================================
`default_nettype none

package hwpe_regmap_pkg;

  // Bus and register data
  localparam int unsigned data_width_p = 32;
  localparam int unsigned addr_width_p = 8;
  localparam int unsigned reg_idx_w_p  = 4;

  // Mandatory registers
  localparam logic [reg_idx_w_p-1:0] reg_trigger_p   = 4'd0;
  localparam logic [reg_idx_w_p-1:0] reg_acquire_p   = 4'd1;
  localparam logic [reg_idx_w_p-1:0] reg_status_p    = 4'd2;
  localparam logic [reg_idx_w_p-1:0] reg_softclear_p = 4'd3;
  localparam logic [reg_idx_w_p-1:0] reg_swevt_p     = 4'd4;

  // Job registers sit in the upper half of the word space
  localparam int unsigned n_job_regs_p = 8;
  localparam int unsigned job_base_p   = 8;
  localparam int unsigned job_idx_w_p  = $clog2(n_job_regs_p);

  localparam int unsigned n_sw_evt_p     = 8;
  localparam int unsigned sw_evt_idx_w_p = $clog2(n_sw_evt_p);

  localparam int unsigned fifo_depth_p = 4;
  localparam int unsigned fifo_ptr_w_p = $clog2(fifo_depth_p);
  localparam int unsigned fifo_cnt_w_p = $clog2(fifo_depth_p + 1);

  localparam int unsigned enable_delay_p = 4;
  localparam int unsigned clear_len_p    = 3;
  localparam int unsigned clear_cnt_w_p  = $clog2(clear_len_p + 1);

  localparam logic [data_width_p-1:0] acquire_denied_p = '1;

endpackage

`default_nettype wire

// ==== rtl/hwpe_ctrl_pkg.sv ====
// ===================================================================
// Control types of the HWPE control slave
// Decoder commands, engine write entries and FSM states
// ===================================================================
`default_nettype none

package hwpe_ctrl_pkg;

  import hwpe_regmap_pkg::*;

  // Single-cycle strobes, valid in the request cycle
  typedef struct packed {
    logic                      trigger;
    logic                      acquire_try;
    logic                      softclear;
    logic                      softclear_regs;
    logic                      swevt;
    logic [sw_evt_idx_w_p-1:0] swevt_idx;
  } ctrl_cmd_t;

  // One engine write to a job register
  typedef struct packed {
    logic [job_idx_w_p-1:0]  idx;
    logic [data_width_p-1:0] data;
  } job_wr_t;

  typedef enum logic [1:0] {
    IDLE,
    STARTING,
    RUN
  } run_state_e;

  typedef enum logic {
    FREE,
    PROGRAM
  } cxt_state_e;

endpackage

`default_nettype wire

// ==== rtl/reg_access_if.sv ====
// ===================================================================
// Bus access port of the job register array
// ===================================================================
`default_nettype none

interface reg_access_if
  import hwpe_regmap_pkg::*;
();

  logic                      req;
  logic                      we;
  logic [job_idx_w_p-1:0]    idx;
  logic [data_width_p-1:0]   wdata;
  logic [data_width_p/8-1:0] be;
  logic [data_width_p-1:0]   rdata;

  modport master (output req, we, idx, wdata, be, input rdata);
  modport slave  (input req, we, idx, wdata, be, output rdata);

endinterface

`default_nettype wire

// ==== rtl/hwme_wr_if.sv ====
// ===================================================================
// Dequeue port of the engine write FIFO
// An entry leaves the queue when valid and pop are both high
// ===================================================================
`default_nettype none

interface hwme_wr_if
  import hwpe_ctrl_pkg::*;
();

  logic    valid;
  logic    pop;
  // Head of the queue
  job_wr_t entry;

  modport source (output valid, entry, input pop);
  modport sink   (input valid, entry, output pop);

endinterface

`default_nettype wire

// ==== rtl/periph_decoder.sv ====
// ===================================================================
// Peripheral bus decoder
// Turns requests into control commands or job register accesses
// and returns the registered read response
// ===================================================================
`default_nettype none

module periph_decoder
  import hwpe_regmap_pkg::*;
  import hwpe_ctrl_pkg::*;
(
  input  logic                      clk_i,
  input  logic                      rst_ni,
  input  logic                      bus_req_i,
  input  logic                      bus_we_i,
  input  logic [addr_width_p-1:0]   bus_addr_i,
  input  logic [data_width_p-1:0]   bus_wdata_i,
  input  logic [data_width_p/8-1:0] bus_be_i,
  output logic [data_width_p-1:0]   bus_rdata_o,
  output logic                      bus_rvalid_o,
  input  logic                      busy_i,
  input  logic                      critical_i,
  output ctrl_cmd_t                 cmd_o,
  reg_access_if.master              regs
);

  logic [reg_idx_w_p-1:0]  idx;
  logic                    in_map;
  logic                    is_job;
  logic                    wr;
  logic                    rd;
  logic [data_width_p-1:0] rdata_d;

  // Word index, upper address bits must be zero for a hit
  assign idx    = bus_addr_i[reg_idx_w_p+1:2];
  assign in_map = (bus_addr_i[addr_width_p-1:reg_idx_w_p+2] == '0);
  assign wr     = bus_req_i & bus_we_i & in_map;
  assign rd     = bus_req_i & ~bus_we_i & in_map;
  assign is_job = in_map && (idx >= job_base_p) && (idx < job_base_p + n_job_regs_p);

  always_comb begin
    cmd_o                = '0;
    cmd_o.trigger        = wr && (idx == reg_trigger_p);
    cmd_o.acquire_try    = rd && (idx == reg_acquire_p);
    cmd_o.softclear      = wr && (idx == reg_softclear_p);
    // Registers are only wiped by a zero write
    cmd_o.softclear_regs = cmd_o.softclear && (bus_wdata_i == '0);
    cmd_o.swevt          = wr && (idx == reg_swevt_p);
    cmd_o.swevt_idx      = bus_wdata_i[sw_evt_idx_w_p-1:0];
  end

  assign regs.req   = bus_req_i & is_job;
  assign regs.we    = bus_we_i;
  assign regs.idx   = job_idx_w_p'(idx - job_base_p);
  assign regs.wdata = bus_wdata_i;
  assign regs.be    = bus_be_i;

  always_comb begin
    rdata_d = '0;
    if (rd) begin
      if (is_job) begin
        rdata_d = regs.rdata;
      end else begin
        case (idx)
          reg_acquire_p: rdata_d = (busy_i || critical_i) ? acquire_denied_p : '0;
          reg_status_p:  rdata_d = {{(data_width_p-2){1'b0}}, critical_i, busy_i};
          default:       rdata_d = '0;
        endcase
      end
    end
  end

  // Every request gets a response one cycle later
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      bus_rvalid_o <= 1'b0;
    end else begin
      bus_rvalid_o <= bus_req_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (bus_req_i) begin
      bus_rdata_o <= rdata_d;
    end
  end

endmodule

`default_nettype wire

// ==== rtl/ctrl_fsm.sv ====
// ===================================================================
// Control state machines of the HWPE slave
// Run and critical-section FSMs, soft clear, events and enable
// ===================================================================
`default_nettype none

module ctrl_fsm
  import hwpe_regmap_pkg::*;
  import hwpe_ctrl_pkg::*;
(
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  ctrl_cmd_t             cmd_i,
  input  logic                  eng_done_i,
  output logic                  start_o,
  output logic                  busy_o,
  output logic                  evt_o,
  output logic [n_sw_evt_p-1:0] sw_evt_o,
  output logic                  enable_o,
  output logic                  clear_o,
  output logic                  clear_regs_o,
  output logic                  critical_o
);

  run_state_e                run_q;
  cxt_state_e                cxt_q;
  logic [clear_cnt_w_p-1:0]  clr_cnt_q;
  logic                      clr_regs_pend_q;
  logic [enable_delay_p-1:0] en_sr_q;
  logic                      true_done;

  // Done only counts while a job is in flight
  assign true_done = eng_done_i & busy_o;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      run_q   <= IDLE;
      start_o <= 1'b0;
      busy_o  <= 1'b0;
      evt_o   <= 1'b0;
    end else if (clear_o) begin
      run_q   <= IDLE;
      start_o <= 1'b0;
      busy_o  <= 1'b0;
      evt_o   <= 1'b0;
    end else begin
      start_o <= 1'b0;
      evt_o   <= true_done;
      case (run_q)
        IDLE: begin
          if (cmd_i.trigger) begin
            run_q  <= STARTING;
            busy_o <= 1'b1;
          end
        end
        STARTING: begin
          if (true_done) begin
            run_q  <= IDLE;
            busy_o <= 1'b0;
          end else begin
            run_q   <= RUN;
            start_o <= 1'b1;
          end
        end
        RUN: begin
          if (true_done) begin
            run_q  <= IDLE;
            busy_o <= 1'b0;
          end
        end
        default: begin
          run_q  <= IDLE;
          busy_o <= 1'b0;
        end
      endcase
    end
  end

  // Critical section: acquire grants it, the trigger write commits
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cxt_q      <= FREE;
      critical_o <= 1'b0;
    end else if (clear_o) begin
      cxt_q      <= FREE;
      critical_o <= 1'b0;
    end else if (cxt_q == FREE && cmd_i.acquire_try && !busy_o) begin
      cxt_q      <= PROGRAM;
      critical_o <= 1'b1;
    end else if (cxt_q == PROGRAM && cmd_i.trigger) begin
      cxt_q      <= FREE;
      critical_o <= 1'b0;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      sw_evt_o <= '0;
    end else begin
      sw_evt_o <= '0;
      if (!clear_o && cmd_i.swevt) begin
        sw_evt_o[cmd_i.swevt_idx] <= 1'b1;
      end
    end
  end

  // Clear window opens one cycle after the counter loads
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      clr_cnt_q       <= '0;
      clr_regs_pend_q <= 1'b0;
      clear_o         <= 1'b0;
      clear_regs_o    <= 1'b0;
    end else begin
      if (cmd_i.softclear && clr_cnt_q == '0) begin
        clr_cnt_q       <= clear_cnt_w_p'(clear_len_p);
        clr_regs_pend_q <= cmd_i.softclear_regs;
      end else if (clr_cnt_q != '0) begin
        clr_cnt_q <= clr_cnt_q - 1'b1;
      end
      clear_o      <= (clr_cnt_q != '0);
      clear_regs_o <= (clr_cnt_q != '0) && clr_regs_pend_q;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      en_sr_q <= '0;
    end else begin
      en_sr_q <= {en_sr_q[enable_delay_p-2:0], 1'b1};
    end
  end

  assign enable_o = en_sr_q[enable_delay_p-1];

endmodule

`default_nettype wire

// ==== rtl/hwme_wr_fifo.sv ====
// ===================================================================
// Engine write FIFO
// Queues engine writes until the register array has a free cycle
// ===================================================================
`default_nettype none

module hwme_wr_fifo
  import hwpe_regmap_pkg::*;
  import hwpe_ctrl_pkg::*;
(
  input  logic                    clk_i,
  input  logic                    rst_ni,
  input  logic                    clear_i,
  input  logic                    hwme_we_i,
  input  logic [job_idx_w_p-1:0]  hwme_idx_i,
  input  logic [data_width_p-1:0] hwme_data_i,
  output logic                    full_o,
  hwme_wr_if.source               deq
);

  job_wr_t                 mem_q [fifo_depth_p];
  logic [fifo_ptr_w_p-1:0] wr_ptr_q;
  logic [fifo_ptr_w_p-1:0] rd_ptr_q;
  logic [fifo_cnt_w_p-1:0] cnt_q;
  logic                    push;
  logic                    pop;

  assign full_o    = (cnt_q == fifo_cnt_w_p'(fifo_depth_p));
  // Writes arriving while full are lost
  assign push      = hwme_we_i & ~full_o;
  assign pop       = deq.valid & deq.pop;
  assign deq.valid = (cnt_q != '0);
  assign deq.entry = mem_q[rd_ptr_q];

  always_ff @(posedge clk_i) begin
    if (push) begin
      mem_q[wr_ptr_q] <= '{idx: hwme_idx_i, data: hwme_data_i};
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      cnt_q    <= '0;
    end else if (clear_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      cnt_q    <= '0;
    end else begin
      if (push) begin
        wr_ptr_q <= (wr_ptr_q == fifo_ptr_w_p'(fifo_depth_p - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (pop) begin
        rd_ptr_q <= (rd_ptr_q == fifo_ptr_w_p'(fifo_depth_p - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      case ({push, pop})
        2'b10:   cnt_q <= cnt_q + 1'b1;
        2'b01:   cnt_q <= cnt_q - 1'b1;
        default: cnt_q <= cnt_q;
      endcase
    end
  end

endmodule

`default_nettype wire

// ==== rtl/ctrl_regfile.sv ====
// ===================================================================
// Job register array
// Bus writes with byte enables, engine writes on idle bus cycles
// ===================================================================
`default_nettype none

module ctrl_regfile
  import hwpe_regmap_pkg::*;
  import hwpe_ctrl_pkg::*;
(
  input  logic                                      clk_i,
  input  logic                                      rst_ni,
  input  logic                                      clear_i,
  reg_access_if.slave                               regs,
  hwme_wr_if.sink                                   deq,
  output logic [n_job_regs_p-1:0][data_width_p-1:0] job_regs_o
);

  logic [n_job_regs_p-1:0][data_width_p-1:0] regs_q;
  job_wr_t                                   hw_entry;
  logic                                      bus_wr;

  assign hw_entry = deq.entry;
  assign bus_wr   = regs.req & regs.we;

  // Drain only when the bus leaves the array alone
  assign deq.pop = deq.valid & ~regs.req;

  assign regs.rdata = regs_q[regs.idx];
  assign job_regs_o = regs_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      regs_q <= '0;
    end else if (clear_i) begin
      regs_q <= '0;
    end else if (bus_wr) begin
      for (int b = 0; b < data_width_p / 8; b++) begin
        if (regs.be[b]) begin
          regs_q[regs.idx][8*b +: 8] <= regs.wdata[8*b +: 8];
        end
      end
    end else if (deq.pop) begin
      // Engine writes always cover the full word
      regs_q[hw_entry.idx] <= hw_entry.data;
    end
  end

endmodule

`default_nettype wire

// ==== rtl/hwpe_ctrl_top.sv ====
// ===================================================================
// HWPE control slave top level
// Bus decoder, control FSMs, engine write FIFO and job registers
// ===================================================================
`default_nettype none

module hwpe_ctrl_top
  import hwpe_regmap_pkg::*;
  import hwpe_ctrl_pkg::*;
(
  input  logic                                 clk_i,
  input  logic                                 rst_ni,
  input  logic                                 bus_req_i,
  input  logic                                 bus_we_i,
  input  logic [addr_width_p-1:0]              bus_addr_i,
  input  logic [data_width_p-1:0]              bus_wdata_i,
  input  logic [data_width_p/8-1:0]            bus_be_i,
  output logic                                 bus_gnt_o,
  output logic [data_width_p-1:0]              bus_rdata_o,
  output logic                                 bus_rvalid_o,
  input  logic                                 eng_done_i,
  input  logic                                 hwme_we_i,
  input  logic [job_idx_w_p-1:0]               hwme_idx_i,
  input  logic [data_width_p-1:0]              hwme_data_i,
  output logic                                 start_o,
  output logic                                 busy_o,
  output logic                                 evt_o,
  output logic [n_sw_evt_p-1:0]                sw_evt_o,
  output logic                                 enable_o,
  output logic                                 clear_o,
  output logic                                 hwme_full_o,
  output logic [n_job_regs_p*data_width_p-1:0] job_regs_o
);

  ctrl_cmd_t                                 cmd;
  logic                                      critical;
  logic                                      clear_regs;
  logic [n_job_regs_p-1:0][data_width_p-1:0] job_regs;

  reg_access_if regs_bus ();
  hwme_wr_if    hwme_deq ();

  // No back-pressure on the bus
  assign bus_gnt_o  = 1'b1;
  assign job_regs_o = job_regs;

  periph_decoder u_periph_decoder (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .bus_req_i    (bus_req_i),
    .bus_we_i     (bus_we_i),
    .bus_addr_i   (bus_addr_i),
    .bus_wdata_i  (bus_wdata_i),
    .bus_be_i     (bus_be_i),
    .bus_rdata_o  (bus_rdata_o),
    .bus_rvalid_o (bus_rvalid_o),
    .busy_i       (busy_o),
    .critical_i   (critical),
    .cmd_o        (cmd),
    .regs         (regs_bus)
  );

  ctrl_fsm u_ctrl_fsm (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .cmd_i        (cmd),
    .eng_done_i   (eng_done_i),
    .start_o      (start_o),
    .busy_o       (busy_o),
    .evt_o        (evt_o),
    .sw_evt_o     (sw_evt_o),
    .enable_o     (enable_o),
    .clear_o      (clear_o),
    .clear_regs_o (clear_regs),
    .critical_o   (critical)
  );

  hwme_wr_fifo u_hwme_wr_fifo (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .clear_i     (clear_o),
    .hwme_we_i   (hwme_we_i),
    .hwme_idx_i  (hwme_idx_i),
    .hwme_data_i (hwme_data_i),
    .full_o      (hwme_full_o),
    .deq         (hwme_deq)
  );

  ctrl_regfile u_ctrl_regfile (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .clear_i    (clear_regs),
    .regs       (regs_bus),
    .deq        (hwme_deq),
    .job_regs_o (job_regs)
  );

endmodule

`default_nettype wire

// ==== tb/tb_clock_gen.sv ====
// ===================================================================
// Testbench clock and reset source
// 4 unit clock period, active low reset held for 4 cycles
// ===================================================================
`default_nettype none

module tb_clock_gen (
  output logic clk_o,
  output logic rst_no
);

  initial begin
    clk_o = 1'b0;
    forever #2 clk_o = ~clk_o;
  end

  // Release on a falling edge, away from the sampling edge
  initial begin
    rst_no = 1'b0;
    repeat (4) @(negedge clk_o);
    rst_no = 1'b1;
  end

endmodule

`default_nettype wire

// ==== tb/tb_hwpe_ctrl.sv ====
// ===================================================================
// Testbench of the HWPE control slave
// Drives bus and engine traffic and checks it against a shadow model
// ===================================================================
`default_nettype none

module tb_hwpe_ctrl
  import hwpe_regmap_pkg::*;
  import hwpe_ctrl_pkg::*;
();

  // Rough cycle budget of each test
  localparam int unsigned reset_cycles    = 10;
  localparam int unsigned job_cycles      = 40;
  localparam int unsigned crit_cycles     = 20;
  localparam int unsigned swevt_cycles    = 16;
  localparam int unsigned clear_cycles    = 40;
  localparam int unsigned engine_cycles   = 80;
  localparam int unsigned watchdog_cycles =
    2 * (reset_cycles + job_cycles + crit_cycles + swevt_cycles + clear_cycles
         + engine_cycles) + 100;

  logic                              clk;
  logic                              rst_n;
  logic                              bus_req;
  logic                              bus_we;
  logic [addr_width_p-1:0]           bus_addr;
  logic [data_width_p-1:0]           bus_wdata;
  logic [data_width_p/8-1:0]         bus_be;
  logic                              bus_gnt;
  logic [data_width_p-1:0]           bus_rdata;
  logic                              bus_rvalid;
  logic                              eng_done;
  logic                              hwme_we;
  logic [job_idx_w_p-1:0]            hwme_idx;
  logic [data_width_p-1:0]           hwme_data;
  logic                              start;
  logic                              busy;
  logic                              evt;
  logic [n_sw_evt_p-1:0]             sw_evt;
  logic                              enable;
  logic                              clear;
  logic                              hwme_full;
  logic [n_job_regs_p*data_width_p-1:0] job_regs;

  logic [31:0]             lcg_state;
  logic [data_width_p-1:0] shadow [n_job_regs_p];
  job_wr_t                 fifo_model [$];
  string                   test_name;
  int                      errors;
  int                      checks;
  int                      dropped;
  logic                    req_q;

  tb_clock_gen u_tb_clock_gen (
    .clk_o  (clk),
    .rst_no (rst_n)
  );

  hwpe_ctrl_top u_hwpe_ctrl_top (
    .clk_i        (clk),
    .rst_ni       (rst_n),
    .bus_req_i    (bus_req),
    .bus_we_i     (bus_we),
    .bus_addr_i   (bus_addr),
    .bus_wdata_i  (bus_wdata),
    .bus_be_i     (bus_be),
    .bus_gnt_o    (bus_gnt),
    .bus_rdata_o  (bus_rdata),
    .bus_rvalid_o (bus_rvalid),
    .eng_done_i   (eng_done),
    .hwme_we_i    (hwme_we),
    .hwme_idx_i   (hwme_idx),
    .hwme_data_i  (hwme_data),
    .start_o      (start),
    .busy_o       (busy),
    .evt_o        (evt),
    .sw_evt_o     (sw_evt),
    .enable_o     (enable),
    .clear_o      (clear),
    .hwme_full_o  (hwme_full),
    .job_regs_o   (job_regs)
  );

  function automatic logic [31:0] next_rand();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  function automatic logic [addr_width_p-1:0] word_addr(input int unsigned widx);
    return addr_width_p'(widx << 2);
  endfunction

  task automatic check_eq(input string label, input logic [31:0] exp, input logic [31:0] act);
    checks++;
    assert (act === exp) else begin
      $display("CHECK FAILED [%s] %s: expected 0x%08h, actual 0x%08h",
               test_name, label, exp, act);
      errors++;
    end
  endtask

  task automatic check_job_regs();
    for (int i = 0; i < n_job_regs_p; i++) begin
      check_eq($sformatf("job_regs_o[%0d]", i), shadow[i], job_regs[32*i +: 32]);
    end
  endtask

  // Called on a falling edge, returns on the falling edge of the response cycle
  task automatic bus_access(input logic we, input logic [addr_width_p-1:0] addr,
                            input logic [31:0] wdata, input logic [3:0] be,
                            output logic [31:0] rdata);
    bus_req   = 1'b1;
    bus_we    = we;
    bus_addr  = addr;
    bus_wdata = wdata;
    bus_be    = be;
    @(negedge clk);
    rdata   = bus_rdata;
    bus_req = 1'b0;
    bus_we  = 1'b0;
  endtask

  task automatic run_soft_clear(input logic [31:0] data);
    logic [31:0] rdata;
    bus_access(1'b1, word_addr(reg_softclear_p), data, 4'hf, rdata);
    check_eq("clear_o before window", 0, clear);
    @(negedge clk);
    check_eq("clear_o cycle 2", 1, clear);
    // Done and a software event raised inside the window stay silent
    eng_done = 1'b1;
    bus_access(1'b1, word_addr(reg_swevt_p), next_rand(), 4'hf, rdata);
    eng_done = 1'b0;
    check_eq("clear_o cycle 3", 1, clear);
    check_eq("evt_o during clear", 0, evt);
    check_eq("sw_evt_o during clear", 0, sw_evt);
    @(negedge clk);
    check_eq("clear_o cycle 4", 1, clear);
    @(negedge clk);
    check_eq("clear_o after window", 0, clear);
    check_eq("busy_o after clear", 0, busy);
  endtask

  // Runs one cycle of engine traffic and models the FIFO and array at the edge
  // bus_kind selects 0 idle, 1 job register read, 2 STATUS read
  task automatic engine_step(input logic push, input job_wr_t wr, input int bus_kind);
    job_wr_t                head;
    logic [job_idx_w_p-1:0] ridx;
    logic [31:0]            exp_rdata;
    int                     pre_size;
    pre_size  = fifo_model.size();
    ridx      = wr.idx + 3'd3;
    exp_rdata = shadow[ridx];
    check_eq("hwme_full_o", pre_size == fifo_depth_p, hwme_full);
    hwme_we   = push;
    hwme_idx  = wr.idx;
    hwme_data = wr.data;
    if (bus_kind == 1) begin
      bus_req  = 1'b1;
      bus_addr = word_addr(job_base_p + ridx);
    end else if (bus_kind == 2) begin
      bus_req  = 1'b1;
      bus_addr = word_addr(reg_status_p);
    end
    // A job register access holds off the drain
    if (pre_size > 0 && bus_kind != 1) begin
      head = fifo_model.pop_front();
      shadow[head.idx] = head.data;
    end
    if (push) begin
      if (pre_size < fifo_depth_p) begin
        fifo_model.push_back(wr);
      end else begin
        dropped++;
      end
    end
    @(negedge clk);
    bus_req = 1'b0;
    hwme_we = 1'b0;
    if (bus_kind == 1) begin
      check_eq($sformatf("read job %0d", ridx), exp_rdata, bus_rdata);
    end else if (bus_kind == 2) begin
      check_eq("STATUS read", 0, bus_rdata);
    end
    check_job_regs();
  endtask

  // Every request gets exactly one response a cycle later
  always @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      req_q <= 1'b0;
    end else begin
      check_eq("bus_rvalid_o", req_q, bus_rvalid);
      check_eq("bus_gnt_o", 1, bus_gnt);
      req_q <= bus_req;
    end
  end

  initial begin : watchdog
    repeat (watchdog_cycles) @(posedge clk);
    $display("Watchdog expired after %0d cycles, the test sequence did not finish",
             watchdog_cycles);
    $display("=== FAIL ===");
    $finish;
  end

  initial begin : stimulus
    logic [31:0]            r;
    logic [31:0]            data;
    logic [31:0]            rdata;
    logic [job_idx_w_p-1:0] idx;
    logic [3:0]             be;
    logic [7:0]             exp_evt;
    job_wr_t                wr;
    int                     kind;
    int                     guard;
    lcg_state = 32'hb62e130b;
    bus_req   = 1'b0;
    bus_we    = 1'b0;
    bus_addr  = '0;
    bus_wdata = '0;
    bus_be    = '0;
    eng_done  = 1'b0;
    hwme_we   = 1'b0;
    hwme_idx  = '0;
    hwme_data = '0;
    errors    = 0;
    checks    = 0;
    dropped   = 0;
    for (int i = 0; i < n_job_regs_p; i++) begin
      shadow[i] = '0;
    end

    test_name = "reset";
    @(posedge rst_n);
    check_eq("start_o", 0, start);
    check_eq("busy_o", 0, busy);
    check_eq("evt_o", 0, evt);
    check_eq("sw_evt_o", 0, sw_evt);
    check_eq("clear_o", 0, clear);
    check_eq("bus_rvalid_o", 0, bus_rvalid);
    check_eq("hwme_full_o", 0, hwme_full);
    for (int k = 1; k <= enable_delay_p; k++) begin
      @(negedge clk);
      check_eq($sformatf("enable_o cycle %0d", k), k >= enable_delay_p, enable);
    end

    test_name = "job_regs";
    for (int i = 0; i < 16; i++) begin
      r    = next_rand();
      idx  = r[2:0];
      be   = r[7:4];
      data = next_rand();
      for (int b = 0; b < 4; b++) begin
        if (be[b]) begin
          shadow[idx][8*b +: 8] = data[8*b +: 8];
        end
      end
      bus_access(1'b1, word_addr(job_base_p + idx), data, be, rdata);
    end
    for (int i = 0; i < n_job_regs_p; i++) begin
      bus_access(1'b0, word_addr(job_base_p + i), '0, 4'hf, rdata);
      check_eq($sformatf("read job %0d", i), shadow[i], rdata);
    end
    check_job_regs();
    bus_access(1'b0, word_addr(5), '0, 4'hf, rdata);
    check_eq("unmapped word 5", 0, rdata);
    bus_access(1'b0, word_addr(7), '0, 4'hf, rdata);
    check_eq("unmapped word 7", 0, rdata);
    bus_access(1'b0, 8'h40, '0, 4'hf, rdata);
    check_eq("unmapped addr 0x40", 0, rdata);
    bus_access(1'b0, 8'hfc, '0, 4'hf, rdata);
    check_eq("unmapped addr 0xfc", 0, rdata);

    test_name = "crit_run";
    // Done while idle has no effect
    eng_done = 1'b1;
    @(negedge clk);
    eng_done = 1'b0;
    check_eq("busy_o on idle done", 0, busy);
    check_eq("evt_o on idle done", 0, evt);
    bus_access(1'b0, word_addr(reg_acquire_p), '0, 4'hf, rdata);
    check_eq("first ACQUIRE", 0, rdata);
    bus_access(1'b0, word_addr(reg_acquire_p), '0, 4'hf, rdata);
    check_eq("second ACQUIRE", 32'hffff_ffff, rdata);
    bus_access(1'b0, word_addr(reg_status_p), '0, 4'hf, rdata);
    check_eq("STATUS critical", 32'h2, rdata);
    bus_access(1'b1, word_addr(reg_trigger_p), next_rand(), 4'hf, rdata);
    check_eq("busy_o at t+1", 1, busy);
    check_eq("start_o at t+1", 0, start);
    @(negedge clk);
    check_eq("start_o at t+2", 1, start);
    @(negedge clk);
    check_eq("start_o at t+3", 0, start);
    bus_access(1'b0, word_addr(reg_status_p), '0, 4'hf, rdata);
    check_eq("STATUS busy", 32'h1, rdata);
    bus_access(1'b0, word_addr(reg_acquire_p), '0, 4'hf, rdata);
    check_eq("ACQUIRE while busy", 32'hffff_ffff, rdata);
    bus_access(1'b0, word_addr(reg_status_p), '0, 4'hf, rdata);
    check_eq("STATUS after denied acquire", 32'h1, rdata);
    eng_done = 1'b1;
    @(negedge clk);
    eng_done = 1'b0;
    check_eq("busy_o after done", 0, busy);
    check_eq("evt_o after done", 1, evt);
    @(negedge clk);
    check_eq("evt_o pulse end", 0, evt);
    bus_access(1'b0, word_addr(reg_status_p), '0, 4'hf, rdata);
    check_eq("STATUS idle", 0, rdata);

    test_name = "sw_events";
    for (int i = 0; i < 6; i++) begin
      data    = next_rand();
      exp_evt = 8'h01 << data[2:0];
      bus_access(1'b1, word_addr(reg_swevt_p), data, 4'hf, rdata);
      check_eq("sw_evt_o pulse", exp_evt, sw_evt);
      @(negedge clk);
      check_eq("sw_evt_o after pulse", 0, sw_evt);
    end

    test_name = "soft_clear";
    bus_access(1'b1, word_addr(reg_trigger_p), '0, 4'hf, rdata);
    check_eq("busy_o before clear", 1, busy);
    run_soft_clear(next_rand() | 32'h1);
    check_job_regs();
    bus_access(1'b0, word_addr(reg_acquire_p), '0, 4'hf, rdata);
    check_eq("ACQUIRE before zero clear", 0, rdata);
    run_soft_clear(32'h0);
    for (int i = 0; i < n_job_regs_p; i++) begin
      shadow[i] = '0;
    end
    check_job_regs();
    bus_access(1'b0, word_addr(reg_status_p), '0, 4'hf, rdata);
    check_eq("STATUS after clear", 0, rdata);
    bus_access(1'b0, word_addr(job_base_p + 2), '0, 4'hf, rdata);
    check_eq("read job 2 after clear", 0, rdata);

    test_name = "engine_writes";
    // The opening burst of job reads stalls the drain until the FIFO overflows
    for (int i = 0; i < 48; i++) begin
      r       = next_rand();
      wr.idx  = r[2:0];
      wr.data = next_rand();
      kind    = (i < 10) ? 1 : int'(r[9:8]) % 3;
      engine_step((i < 10) || (r[5:4] != 2'b00), wr, kind);
    end
    guard = 0;
    while (fifo_model.size() > 0 && guard < 4 * fifo_depth_p) begin
      engine_step(1'b0, wr, 0);
      guard++;
    end
    for (int i = 0; i < n_job_regs_p; i++) begin
      bus_access(1'b0, word_addr(job_base_p + i), '0, 4'hf, rdata);
      check_eq($sformatf("final read job %0d", i), shadow[i], rdata);
    end
    check_job_regs();

    @(negedge clk);
    $display("Checks: %0d, errors: %0d, dropped engine writes: %0d",
             checks, errors, dropped);
    if (errors == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== hwpe_ctrl_top.f ====
rtl/hwpe_regmap_pkg.sv
rtl/hwpe_ctrl_pkg.sv
rtl/reg_access_if.sv
rtl/hwme_wr_if.sv
rtl/periph_decoder.sv
rtl/ctrl_fsm.sv
rtl/hwme_wr_fifo.sv
rtl/ctrl_regfile.sv
rtl/hwpe_ctrl_top.sv
tb/tb_clock_gen.sv
tb/tb_hwpe_ctrl.sv
